// ==== source/cache_pkg.sv ====
package cache_pkg;

	// address and storage geometry
	localparam int BW_WORD_ADDR    = 24;  // core word address
	localparam int BW_TAG          = 14;
	localparam int BW_GROUP        = 6;
	localparam int BW_WORD         = 4;   // word inside block
	localparam int N_GROUPS        = 64;
	localparam int N_WAYS          = 2;
	localparam int WORDS_PER_BLOCK = 16;

	// comm port
	localparam logic [31:0] CACHE_ID = 32'h2F1F_0C02;  // fifo, 2-way set assoc
	localparam int COMM_CNT_EN_BIT   = 24;              // counting enable in comm_i

	localparam logic [3:0] COMM_SEL_HIT_LO  = 4'd0;
	localparam logic [3:0] COMM_SEL_HIT_HI  = 4'd1;
	localparam logic [3:0] COMM_SEL_MISS_LO = 4'd2;
	localparam logic [3:0] COMM_SEL_MISS_HI = 4'd3;
	localparam logic [3:0] COMM_SEL_WB_LO   = 4'd4;
	localparam logic [3:0] COMM_SEL_WB_HI   = 4'd5;
	localparam logic [3:0] COMM_SEL_CYC_LO  = 4'd6;
	localparam logic [3:0] COMM_SEL_CYC_HI  = 4'd7;
	localparam logic [3:0] COMM_SEL_ID      = 4'd14;

	// vector types
	typedef logic [BW_WORD_ADDR-1:0] word_addr_t;  // {tag, group, word}
	typedef logic [BW_TAG-1:0]       tag_t;
	typedef logic [BW_GROUP-1:0]     group_t;
	typedef logic [BW_WORD-1:0]      word_off_t;
	typedef logic                    way_t;
	typedef logic [31:0]             data_t;
	typedef logic [10:0]             cache_addr_t; // {way, group, word}
	typedef logic [63:0]             counter_t;

	// directory -> controller
	typedef struct packed {
		logic hit;
		way_t hit_way;
		way_t victim_way;    // fifo pointer of the group
		tag_t victim_tag;
		logic victim_dirty;  // valid and dirty
	} dir_lookup_t;

	// controller -> directory, applied at the edge
	typedef struct packed {
		logic   fill;
		logic   mark_dirty;
		way_t   way;
		group_t group;
	} dir_update_t;

	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} perf_event_t;

	typedef enum logic [2:0] {
		ST_LOOKUP,
		ST_RESPOND,
		ST_WRITE_BUF,
		ST_WB_REQ,
		ST_FETCH_REQ,
		ST_READ_BUF
	} ctrl_state_t;

endpackage

// ==== source/cache_set_directory.sv ====
`timescale 1ns/100ps

module cache_set_directory
	import cache_pkg::*;
(
	input  logic        clock_bus_i,
	input  logic        reset_i,
	input  tag_t        tag_i,     // from core address
	input  group_t      group_i,
	input  dir_update_t update_i,
	output dir_lookup_t lookup_o
);

	tag_t tag_q [N_WAYS][N_GROUPS];         // tag store, no reset
	logic [N_WAYS-1:0][N_GROUPS-1:0] valid_q;
	logic [N_WAYS-1:0][N_GROUPS-1:0] dirty_q;
	logic [N_GROUPS-1:0] fifo_ptr_q;        // next way to replace

	logic [N_WAYS-1:0] hit_vec;
	way_t              vic_way;

	// ------------------------------------------------------------
	// lookup, both ways compared in parallel
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < N_WAYS; w++) begin
			hit_vec[w] = valid_q[w][group_i] && (tag_q[w][group_i] == tag_i);
		end
	end

	assign vic_way = fifo_ptr_q[group_i];

	assign lookup_o.hit          = |hit_vec;
	assign lookup_o.hit_way      = hit_vec[1];                    // only two ways
	assign lookup_o.victim_way   = vic_way;
	assign lookup_o.victim_tag   = tag_q[vic_way][group_i];
	assign lookup_o.victim_dirty = valid_q[vic_way][group_i] && dirty_q[vic_way][group_i];

	// ------------------------------------------------------------
	// updates from the controller
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (update_i.fill) begin
			tag_q[update_i.way][update_i.group] <= tag_i;  // core holds missing address
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			valid_q    <= '0;
			dirty_q    <= '0;
			fifo_ptr_q <= '0;  // all groups start at way 0
		end else if (update_i.fill) begin
			valid_q[update_i.way][update_i.group] <= 1'b1;
			dirty_q[update_i.way][update_i.group] <= 1'b0;  // fresh block is clean
			fifo_ptr_q[update_i.group]            <= ~fifo_ptr_q[update_i.group];
		end else if (update_i.mark_dirty) begin
			dirty_q[update_i.way][update_i.group] <= 1'b1;
		end
	end

endmodule

// ==== source/cache_data_ram.sv ====
`timescale 1ns/100ps

module cache_data_ram
	import cache_pkg::*;
(
	input  logic        clock_bus_i,
	input  cache_addr_t addr_i,
	input  logic        wren_i,
	input  data_t       data_i,
	output data_t       data_o
);

	localparam int DEPTH = N_WAYS * N_GROUPS * WORDS_PER_BLOCK;  // 2048 words

	data_t mem [DEPTH];

	// single port, read-first
	always_ff @(posedge clock_bus_i) begin
		if (wren_i) begin
			mem[addr_i] <= data_i;
		end
		data_o <= mem[addr_i];  // old contents on a write
	end

endmodule

// ==== source/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller
	import cache_pkg::*;
(
	input  logic        clock_bus_i,
	input  logic        reset_i,
	input  logic        en_i,
	input  logic        core_req_i,
	input  logic        core_rw_i,
	input  word_addr_t  core_add_i,
	input  data_t       core_data_i,
	output logic        core_done_o,

	input  dir_lookup_t lookup_i,
	output dir_update_t update_o,

	output cache_addr_t ram_addr_o,
	output logic        ram_wren_o,
	output data_t       ram_data_o,
	input  data_t       ram_data_i,

	input  logic        ready_req_i,
	input  logic        ready_write_i,
	input  logic        ready_read_i,
	input  data_t       data_i,
	output logic        req_o,
	output logic        rw_o,
	output logic        write_o,
	output logic        read_o,
	output word_addr_t  add_o,
	output data_t       data_o,

	output perf_event_t perf_o
);

	ctrl_state_t state_q, state_d;
	word_off_t   cnt_q, cnt_d;       // words moved in current burst
	way_t        vic_way_q;          // latched on miss
	tag_t        vic_tag_q;
	logic        latch_victim;

	tag_t      req_tag;
	group_t    req_group;
	word_off_t req_word;
	logic      last_word;

	// core address fields, stable while request held
	assign req_tag   = core_add_i[BW_WORD_ADDR-1 -: BW_TAG];
	assign req_group = core_add_i[BW_WORD +: BW_GROUP];
	assign req_word  = core_add_i[BW_WORD-1:0];
	assign last_word = (cnt_q == word_off_t'(WORDS_PER_BLOCK - 1));

	// buffer side, address and payload always presented
	assign rw_o       = (state_q == ST_WB_REQ);  // write-back vs fetch
	assign add_o      = (state_q == ST_WB_REQ) ? {vic_tag_q, req_group, word_off_t'(0)}
	                                           : {req_tag, req_group, word_off_t'(0)};
	assign data_o     = ram_data_i;              // victim word, one ahead
	assign core_done_o = en_i && (state_q == ST_RESPOND);

	// ------------------------------------------------------------
	// next state and strokes
	// ------------------------------------------------------------
	always_comb begin
		state_d      = state_q;
		cnt_d        = cnt_q;
		latch_victim = 1'b0;
		req_o        = 1'b0;
		write_o      = 1'b0;
		read_o       = 1'b0;
		ram_addr_o   = {vic_way_q, req_group, cnt_q};
		ram_wren_o   = 1'b0;
		ram_data_o   = data_i;
		update_o     = '{fill: 1'b0, mark_dirty: 1'b0, way: vic_way_q, group: req_group};
		perf_o       = '0;

		case (state_q)
			ST_LOOKUP: begin
				if (lookup_i.hit) begin
					ram_addr_o = {lookup_i.hit_way, req_group, req_word};
				end else begin
					ram_addr_o = {lookup_i.victim_way, req_group, word_off_t'(0)};  // prefetch word 0
				end
				if (en_i && core_req_i) begin
					if (lookup_i.hit) begin
						ram_wren_o          = core_rw_i;
						ram_data_o          = core_data_i;
						update_o.mark_dirty = core_rw_i;
						update_o.way        = lookup_i.hit_way;
						perf_o.hit          = 1'b1;
						state_d             = ST_RESPOND;
					end else begin
						latch_victim = 1'b1;
						perf_o.miss  = 1'b1;
						cnt_d        = '0;
						state_d      = lookup_i.victim_dirty ? ST_WRITE_BUF : ST_FETCH_REQ;
					end
				end
			end

			ST_RESPOND: begin
				ram_addr_o = {lookup_i.hit_way, req_group, req_word};  // read word held while frozen
				if (en_i) state_d = ST_LOOKUP;  // core_req_i ignored here
			end

			// stream victim out, ram read runs one word ahead
			ST_WRITE_BUF: begin
				if (en_i && ready_write_i) begin
					write_o    = 1'b1;
					ram_addr_o = {vic_way_q, req_group, cnt_q + 1'b1};
					cnt_d      = cnt_q + 1'b1;
					if (last_word) state_d = ST_WB_REQ;
				end
			end

			ST_WB_REQ: begin
				if (en_i && ready_req_i) begin
					req_o            = 1'b1;
					perf_o.writeback = 1'b1;
					state_d          = ST_FETCH_REQ;
				end
			end

			ST_FETCH_REQ: begin
				if (en_i && ready_req_i) begin
					req_o   = 1'b1;
					cnt_d   = '0;
					state_d = ST_READ_BUF;
				end
			end

			// refill victim way, fill directory on the last word
			ST_READ_BUF: begin
				if (en_i && ready_read_i) begin
					read_o     = 1'b1;
					ram_wren_o = 1'b1;
					cnt_d      = cnt_q + 1'b1;
					if (last_word) begin
						update_o.fill = 1'b1;
						state_d       = ST_LOOKUP;  // retry hits
					end
				end
			end

			default: state_d = ST_LOOKUP;
		endcase
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state_q <= ST_LOOKUP;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (latch_victim) begin
			vic_way_q <= lookup_i.victim_way;
			vic_tag_q <= lookup_i.victim_tag;  // for write-back address
		end
	end

endmodule

// ==== source/cache_perf_regs.sv ====
`timescale 1ns/100ps

module cache_perf_regs
	import cache_pkg::*;
(
	input  logic        clock_bus_i,
	input  logic        reset_i,
	input  perf_event_t perf_i,
	input  data_t       comm_i,
	output data_t       comm_o
);

	counter_t hit_cnt_q, miss_cnt_q, wb_cnt_q, cyc_cnt_q;
	logic     cnt_en;

	assign cnt_en = comm_i[COMM_CNT_EN_BIT];

	// ------------------------------------------------------------
	// counters
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			hit_cnt_q  <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
			cyc_cnt_q  <= '0;
		end else if (cnt_en) begin
			if (perf_i.hit)            hit_cnt_q  <= hit_cnt_q + 1'b1;
			else if (perf_i.miss)      miss_cnt_q <= miss_cnt_q + 1'b1;
			else if (perf_i.writeback) wb_cnt_q   <= wb_cnt_q + 1'b1;
			cyc_cnt_q <= cyc_cnt_q + 1'b1;  // wall clock while enabled
		end
	end

	// readout, one cycle after select
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			comm_o <= '0;
		end else begin
			case (comm_i[3:0])
				COMM_SEL_HIT_LO:  comm_o <= hit_cnt_q[31:0];
				COMM_SEL_HIT_HI:  comm_o <= hit_cnt_q[63:32];
				COMM_SEL_MISS_LO: comm_o <= miss_cnt_q[31:0];
				COMM_SEL_MISS_HI: comm_o <= miss_cnt_q[63:32];
				COMM_SEL_WB_LO:   comm_o <= wb_cnt_q[31:0];
				COMM_SEL_WB_HI:   comm_o <= wb_cnt_q[63:32];
				COMM_SEL_CYC_LO:  comm_o <= cyc_cnt_q[31:0];
				COMM_SEL_CYC_HI:  comm_o <= cyc_cnt_q[63:32];
				COMM_SEL_ID:      comm_o <= CACHE_ID;
				default:          comm_o <= '0;
			endcase
		end
	end

endmodule

// ==== source/cache_top.sv ====
`timescale 1ns/100ps

module cache_top
	import cache_pkg::*;
(
	input  logic       clock_bus_i,
	input  logic       reset_i,
	input  logic       en_i,
	input  data_t      comm_i,
	output data_t      comm_o,

	// core side
	input  logic       core_req_i,
	input  logic       core_rw_i,
	input  word_addr_t core_add_i,
	input  data_t      core_data_i,
	output logic       core_done_o,
	output data_t      core_data_o,  // straight from ram read port

	// block buffer side
	input  logic       ready_req_i,
	input  logic       ready_write_i,
	input  logic       ready_read_i,
	input  data_t      data_i,
	output logic       req_o,
	output logic       rw_o,
	output logic       write_o,
	output logic       read_o,
	output word_addr_t add_o,
	output data_t      data_o
);

	dir_lookup_t lookup;
	dir_update_t update;
	cache_addr_t ram_addr;
	logic        ram_wren;
	data_t       ram_wdata;
	perf_event_t perf;

	cache_set_directory i_directory (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.tag_i       (core_add_i[BW_WORD_ADDR-1 -: BW_TAG]),
		.group_i     (core_add_i[BW_WORD +: BW_GROUP]),
		.update_i    (update),
		.lookup_o    (lookup)
	);

	cache_data_ram i_data_ram (
		.clock_bus_i (clock_bus_i),
		.addr_i      (ram_addr),
		.wren_i      (ram_wren),
		.data_i      (ram_wdata),
		.data_o      (core_data_o)
	);

	cache_controller i_controller (
		.clock_bus_i   (clock_bus_i),
		.reset_i       (reset_i),
		.en_i          (en_i),
		.core_req_i    (core_req_i),
		.core_rw_i     (core_rw_i),
		.core_add_i    (core_add_i),
		.core_data_i   (core_data_i),
		.core_done_o   (core_done_o),
		.lookup_i      (lookup),
		.update_o      (update),
		.ram_addr_o    (ram_addr),
		.ram_wren_o    (ram_wren),
		.ram_data_o    (ram_wdata),
		.ram_data_i    (core_data_o),  // victim words read back here
		.ready_req_i   (ready_req_i),
		.ready_write_i (ready_write_i),
		.ready_read_i  (ready_read_i),
		.data_i        (data_i),
		.req_o         (req_o),
		.rw_o          (rw_o),
		.write_o       (write_o),
		.read_o        (read_o),
		.add_o         (add_o),
		.data_o        (data_o),
		.perf_o        (perf)
	);

	cache_perf_regs i_perf_regs (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.perf_i      (perf),
		.comm_i      (comm_i),
		.comm_o      (comm_o)
	);

endmodule

// ==== test/cache_clock_gen.sv ====
`timescale 1ns/100ps

module cache_clock_gen (
	output logic clock_bus_o,
	output logic reset_o
);

	initial begin
		clock_bus_o = 1'b0;
		forever #2 clock_bus_o = ~clock_bus_o;  // 4 ns period
	end

	// active low, released after 16 edges
	initial begin
		reset_o = 1'b0;
		repeat (16) @(posedge clock_bus_o);
		reset_o <= 1'b1;
	end

endmodule

// ==== test/cache_props.sv ====
`timescale 1ns/100ps

module cache_props (
	input logic clock_bus_i,
	input logic reset_i,
	input logic core_done_i,
	input logic req_i,
	input logic write_i,
	input logic read_i,
	input logic ready_req_i,
	input logic ready_write_i,
	input logic ready_read_i
);

	int fail_count = 0;  // failed assertions so far

	// ------------------------------------------------------------
	// core side
	// ------------------------------------------------------------
	done_pulse: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		core_done_i |=> !core_done_i)
		else begin
			fail_count++;
			$error("core_done_o high for two cycles");
		end

	// ------------------------------------------------------------
	// buffer strokes only under their ready levels
	// ------------------------------------------------------------
	req_ready: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		req_i |-> ready_req_i)
		else begin
			fail_count++;
			$error("req_o without ready_req_i");
		end

	write_ready: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		write_i |-> ready_write_i)
		else begin
			fail_count++;
			$error("write_o without ready_write_i");
		end

	read_ready: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		read_i |-> ready_read_i)
		else begin
			fail_count++;
			$error("read_o without ready_read_i");
		end

	no_write_read: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		!(write_i && read_i))
		else begin
			fail_count++;
			$error("write_o and read_o in the same cycle");
		end

endmodule

bind cache_controller cache_props i_props (
	.clock_bus_i   (clock_bus_i),
	.reset_i       (reset_i),
	.core_done_i   (core_done_o),
	.req_i         (req_o),
	.write_i       (write_o),
	.read_i        (read_o),
	.ready_req_i   (ready_req_i),
	.ready_write_i (ready_write_i),
	.ready_read_i  (ready_read_i)
);

// ==== test/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb
	import cache_pkg::*;
();

	localparam int N_REQ       = 400;  // random requests, counting on
	localparam int N_FROZEN    = 20;   // more requests, counting off
	localparam int CLK_NS      = 4;
	localparam int WATCHDOG_NS = (N_REQ + N_FROZEN) * 200 * CLK_NS;

	logic       clock_bus, reset;
	logic       en, core_req, core_rw, core_done;
	word_addr_t core_add, buf_add;
	data_t      core_wdata, core_rdata, comm, comm_rd;
	logic       ready_req, ready_write, ready_read;
	logic       buf_req, buf_rw, buf_write, buf_read;
	data_t      buf_rdata, buf_wdata;

	// reference model
	data_t ref_mem [word_addr_t];  // value the core must see
	data_t ext_mem [word_addr_t];  // memory behind the buffer
	tag_t  ref_tag   [N_WAYS][N_GROUPS];
	logic  ref_valid [N_WAYS][N_GROUPS];
	logic  ref_dirty [N_WAYS][N_GROUPS];
	way_t  ref_ptr   [N_GROUPS];
	int    n_miss, n_wb;

	word_addr_t exp_wb_q [$];     // victim block addresses in order
	word_addr_t exp_fetch_q [$];
	data_t      wr_q [$];         // words streamed out so far
	data_t      rd_q [$];         // words waiting for read strokes

	int   err_value, err_other;
	logic cnt_en;

	tag_t   tag_pool   [5] = '{14'h0000, 14'h0001, 14'h1337, 14'h2a5c, 14'h3fff};
	group_t group_pool [4] = '{6'd0, 6'd1, 6'd33, 6'd63};

	cache_clock_gen i_clock_gen (.clock_bus_o(clock_bus), .reset_o(reset));

	cache_top i_cache_top (
		.clock_bus_i (clock_bus),   .reset_i       (reset),       .en_i         (en),
		.comm_i      (comm),        .comm_o        (comm_rd),
		.core_req_i  (core_req),    .core_rw_i     (core_rw),     .core_add_i   (core_add),
		.core_data_i (core_wdata),  .core_done_o   (core_done),   .core_data_o  (core_rdata),
		.ready_req_i (ready_req),   .ready_write_i (ready_write), .ready_read_i (ready_read),
		.data_i      (buf_rdata),   .req_o         (buf_req),     .rw_o         (buf_rw),
		.write_o     (buf_write),   .read_o        (buf_read),    .add_o        (buf_add),
		.data_o      (buf_wdata)
	);

	// ------------------------------------------------------------
	// model helpers and compare tasks
	// ------------------------------------------------------------
	function automatic data_t init_word(word_addr_t a);
		return {~a[7:0], a};  // unwritten memory
	endfunction

	function automatic data_t ref_value(word_addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
	endfunction

	function automatic data_t ext_value(word_addr_t a);
		return ext_mem.exists(a) ? ext_mem[a] : init_word(a);
	endfunction

	task automatic check_data(string name, data_t got, data_t exp_word);
		if (got !== exp_word) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp_word);
			err_value++;
		end
	endtask

	task automatic check_addr(string name, word_addr_t got, word_addr_t exp_addr);
		if (got !== exp_addr) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp_addr);
			err_value++;
		end
	endtask

	task automatic check_count(string name, counter_t got, counter_t exp_cnt);
		if (got !== exp_cnt) begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp_cnt);
			err_value++;
		end
	endtask

	task automatic report_error(string what);
		$display("ERROR %0t %s", $time, what);
		err_other++;
	endtask

	// ------------------------------------------------------------
	// core side
	// ------------------------------------------------------------
	task automatic run_request(logic is_store, word_addr_t addr, data_t wdata);
		tag_t   tag;
		group_t grp;
		way_t   way;
		logic   hit;
		data_t  exp_word;
		int     cycles;
		tag = addr[BW_WORD_ADDR-1 -: BW_TAG];
		grp = addr[BW_WORD +: BW_GROUP];
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < N_WAYS; w++) begin
			if (ref_valid[w][grp] && ref_tag[w][grp] == tag) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		if (!hit) begin
			way = ref_ptr[grp];  // fifo victim, valid or not
			n_miss++;
			if (ref_valid[way][grp] && ref_dirty[way][grp]) begin
				exp_wb_q.push_back({ref_tag[way][grp], grp, word_off_t'(0)});
				n_wb++;
			end
			exp_fetch_q.push_back({tag, grp, word_off_t'(0)});
			ref_tag[way][grp]   = tag;
			ref_valid[way][grp] = 1'b1;
			ref_dirty[way][grp] = 1'b0;
			ref_ptr[grp]        = ~ref_ptr[grp];
		end
		exp_word = ref_value(addr);
		if (is_store) begin
			ref_mem[addr]       = wdata;
			ref_dirty[way][grp] = 1'b1;
		end

		@(posedge clock_bus);
		core_req   <= 1'b1;
		core_rw    <= is_store;
		core_add   <= addr;
		core_wdata <= wdata;

		// only enabled cycles count, en_i low freezes the controller
		cycles = 0;
		do begin
			@(negedge clock_bus);
			if (en) cycles++;
		end while (core_done !== 1'b1);
		if (hit && cycles != 2)
			report_error($sformatf("hit at %h took %0d enabled cycles to done instead of 1",
				addr, cycles - 1));
		if (!is_store) check_data("core_data_o", core_rdata, exp_word);
	endtask

	task automatic issue_random();
		word_addr_t addr;
		addr = {tag_pool[$urandom % 5], group_pool[$urandom % 4], word_off_t'($urandom)};
		if ($urandom % 4 == 0) begin  // idle gap
			@(posedge clock_bus);
			core_req <= 1'b0;
			repeat ($urandom % 3) @(posedge clock_bus);
		end
		run_request(($urandom % 2) == 1, addr, $urandom);
	endtask

	task automatic drop_request();
		@(posedge clock_bus);
		core_req <= 1'b0;
	endtask

	// comm word shows up one cycle after the select
	task automatic read_comm(logic [3:0] sel, output data_t word);
		@(posedge clock_bus);
		comm <= {7'b0, cnt_en, 20'b0, sel};
		@(posedge clock_bus);
		@(negedge clock_bus);
		word = comm_rd;
	endtask

	task automatic read_counter(logic [3:0] sel_lo, output counter_t value);
		data_t lo, hi;
		read_comm(sel_lo, lo);
		read_comm(sel_lo + 4'd1, hi);
		value = {hi, lo};
	endtask

	// ------------------------------------------------------------
	// buffer and memory model
	// ------------------------------------------------------------
	task automatic accept_writeback();
		word_addr_t exp_addr;
		if (exp_wb_q.size() == 0) begin
			report_error($sformatf("write-back of %h without a dirty eviction", buf_add));
			wr_q.delete();
			return;
		end
		exp_addr = exp_wb_q.pop_front();
		check_addr("add_o", buf_add, exp_addr);
		if (wr_q.size() != WORDS_PER_BLOCK)
			report_error($sformatf("write-back came after %0d words", wr_q.size()));
		for (int i = 0; i < wr_q.size(); i++) begin
			check_data("data_o", wr_q[i], ref_value(exp_addr + word_addr_t'(i)));
			ext_mem[exp_addr + word_addr_t'(i)] = wr_q[i];
		end
		wr_q.delete();
	endtask

	task automatic accept_fetch();
		if (exp_wb_q.size() != 0) report_error("fetch before the expected write-back");
		if (exp_fetch_q.size() == 0) begin
			report_error($sformatf("fetch of %h without a miss", buf_add));
			return;
		end
		check_addr("add_o", buf_add, exp_fetch_q.pop_front());
		for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
			rd_q.push_back(ext_value(buf_add + word_addr_t'(i)));
		end
	endtask

	initial begin
		ready_req   = 1'b0;
		ready_write = 1'b0;
		ready_read  = 1'b0;
		buf_rdata   = '0;
		wait (reset === 1'b1);
		forever begin
			@(negedge clock_bus);  // strokes settled here
			if (!en && (buf_req || buf_write || buf_read || core_done))
				report_error("stroke or done while en_i is low");
			if (buf_write) wr_q.push_back(buf_wdata);
			if (buf_read) begin
				if (rd_q.size() == 0) report_error("read stroke with no word queued");
				else void'(rd_q.pop_front());
			end
			if (buf_req) begin
				if (buf_rw) accept_writeback();
				else accept_fetch();
			end
			@(posedge clock_bus);
			ready_req   <= ($urandom % 4 != 0);
			ready_write <= ($urandom % 4 != 0);
			ready_read  <= (rd_q.size() > 0) && ($urandom % 4 != 0);  // low while empty
			buf_rdata   <= (rd_q.size() > 0) ? rd_q[0] : '0;
		end
	end

	// ------------------------------------------------------------
	// en_i drops low for random stretches anywhere in an access
	// ------------------------------------------------------------
	initial begin
		int off_cycles;
		en         = 1'b0;
		off_cycles = 0;
		wait (reset === 1'b1);
		forever begin
			@(posedge clock_bus);
			if (off_cycles > 0) begin
				en <= 1'b0;
				off_cycles--;
			end else begin
				en <= 1'b1;
				if ($urandom % 16 == 0) off_cycles = int'($urandom % 6) + 1;
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus and final checks
	// ------------------------------------------------------------
	initial begin
		counter_t cnt, cyc_frozen;
		data_t    word;
		comm       = '0;
		core_req   = 1'b0;
		core_rw    = 1'b0;
		core_add   = '0;
		core_wdata = '0;
		cnt_en     = 1'b1;
		err_value  = 0;
		err_other  = 0;
		n_miss     = 0;
		n_wb       = 0;
		void'($urandom(32'h1e95));
		for (int g = 0; g < N_GROUPS; g++) begin
			ref_ptr[g] = 1'b0;
			for (int w = 0; w < N_WAYS; w++) begin
				ref_valid[w][g] = 1'b0;
				ref_dirty[w][g] = 1'b0;
			end
		end
		wait (reset === 1'b1);
		@(posedge clock_bus);
		comm <= {7'b0, cnt_en, 20'b0, 4'd0};

		for (int n = 0; n < N_REQ; n++) issue_random();
		drop_request();

		// every request ends with a hit, misses retry
		read_counter(COMM_SEL_HIT_LO, cnt);
		check_count("hit counter", cnt, counter_t'(N_REQ));
		read_counter(COMM_SEL_MISS_LO, cnt);
		check_count("miss counter", cnt, counter_t'(n_miss));
		read_counter(COMM_SEL_WB_LO, cnt);
		check_count("write-back counter", cnt, counter_t'(n_wb));
		read_comm(COMM_SEL_ID, word);
		check_count("comm_o id", counter_t'(word), counter_t'(CACHE_ID));
		read_comm(4'd9, word);
		check_count("comm_o unused select", counter_t'(word), '0);

		// counting off
		cnt_en = 1'b0;
		read_counter(COMM_SEL_CYC_LO, cyc_frozen);
		for (int n = 0; n < N_FROZEN; n++) issue_random();
		drop_request();
		read_counter(COMM_SEL_HIT_LO, cnt);
		check_count("frozen hit counter", cnt, counter_t'(N_REQ));
		read_counter(COMM_SEL_CYC_LO, cnt);
		check_count("frozen cycle counter", cnt, cyc_frozen);

		if (exp_wb_q.size() != 0) report_error("expected write-back never came");
		if (exp_fetch_q.size() != 0) report_error("expected fetch never came");
		if (rd_q.size() != 0 || wr_q.size() != 0) report_error("buffer words left over");
		err_other += i_cache_top.i_controller.i_props.fail_count;

		$display("errors: %0d value, %0d protocol", err_value, err_other);
		if (err_value == 0 && err_other == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("ERROR %0t timeout, the DUT stopped answering", $time);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
source/cache_pkg.sv
source/cache_set_directory.sv
source/cache_data_ram.sv
source/cache_controller.sv
source/cache_perf_regs.sv
source/cache_top.sv
test/cache_clock_gen.sv
test/cache_props.sv
test/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
RTL_TOP   ?= cache_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --assert -j 0

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
